/* hdl/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Datapath width
`define ALU_W 8

// One BCD digit
`define ALU_NIB 4

`define ALU_BCD_ADJ 6 // Decimal adjust per nibble

// Command to result, in phi2 cycles
`define ALU_LATENCY 3

`endif

/* hdl/alu_ctrl_pkg.sv */
package alu_ctrl_pkg;

	typedef enum logic [2:0] {
		op_and = 3'd0,
		op_or  = 3'd1,
		op_eor = 3'd2,
		op_sum = 3'd3,
		op_sr  = 3'd4
	} alu_op_e;

	// AI input source
	typedef enum logic [1:0] {
		a_zero = 2'd0,
		a_sb   = 2'd1,
		a_ac   = 2'd2
	} a_src_e;

	// BI input source, ndb is the subtract path
	typedef enum logic [1:0] {
		b_db  = 2'd0,
		b_ndb = 2'd1,
		b_adl = 2'd2
	} b_src_e;

	typedef struct packed {
		alu_op_e op;
		a_src_e  a_src;
		b_src_e  b_src;
		logic    carry_in;
		logic    decimal;
		logic    to_ac;    // Write accumulator
		logic    to_sb;    // Result onto special bus
		logic    to_adl;   // Result onto address low bus
	} alu_cmd_t;

	typedef struct packed {
		logic z_add, sb_add, ac_add;  // AI loads
		logic db_add, ndb_add, adl_add;  // BI loads
		logic ands, ors, eors, sums, srs;
		logic acin;
		logic daa, dsa;
		logic sb_ac, add_sb, add_adl; // Passed through to the result stage
	} alu_ctrl_t;

endpackage

/* hdl/alu_data_pkg.sv */
package alu_data_pkg;

`include "alu_consts.svh"

	typedef struct packed {
		logic [`ALU_W-1:0] sb;
		logic [`ALU_W-1:0] db;
		logic [`ALU_W-1:0] adl;
	} alu_bus_t;

	typedef struct packed {
		logic acr; // Carry
		logic avr; // Overflow
	} alu_flags_t;

	// Adder hold plus what the BCD correction needs
	typedef struct packed {
		logic [`ALU_W-1:0] add;
		alu_flags_t        flags;
		logic              dc;      // Decimal half carry
		logic [1:0]        nib_c;   // Binary carry out of each nibble
		logic              daa;
		logic              dsa;
		logic              sb_ac;
		logic              add_sb;
		logic              add_adl;
	} alu_hold_t;

endpackage

/* hdl/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode
	import alu_ctrl_pkg::*, alu_data_pkg::*;
(
	input  logic      phi2,
	input  logic      rst_n,
	input  logic      cmd_valid,
	input  alu_cmd_t  cmd,
	input  alu_bus_t  bus,
	output logic      ctrl_valid,
	output alu_ctrl_t ctrl,
	output alu_bus_t  bus_q
);

	alu_ctrl_t ctrl_d;
	logic      is_sum;

	assign is_sum = (cmd.op == op_sum);

	always_comb begin
		ctrl_d = '0;

		ctrl_d.z_add   = (cmd.a_src == a_zero);
		ctrl_d.sb_add  = (cmd.a_src == a_sb);
		ctrl_d.ac_add  = (cmd.a_src == a_ac);

		ctrl_d.db_add  = (cmd.b_src == b_db);
		ctrl_d.ndb_add = (cmd.b_src == b_ndb);
		ctrl_d.adl_add = (cmd.b_src == b_adl);

		ctrl_d.ands = (cmd.op == op_and);
		ctrl_d.ors  = (cmd.op == op_or);
		ctrl_d.eors = (cmd.op == op_eor);
		ctrl_d.sums = is_sum;
		ctrl_d.srs  = (cmd.op == op_sr);

		ctrl_d.acin = cmd.carry_in;

		// Decimal mode only matters for the adder
		ctrl_d.daa = cmd.decimal & is_sum & (cmd.b_src == b_db);
		ctrl_d.dsa = cmd.decimal & is_sum & (cmd.b_src == b_ndb);

		ctrl_d.sb_ac   = cmd.to_ac;
		ctrl_d.add_sb  = cmd.to_sb;
		ctrl_d.add_adl = cmd.to_adl;
	end

	always_ff @(posedge phi2) begin
		if (!rst_n) begin
			ctrl_valid <= 1'b0;
		end else begin
			ctrl_valid <= cmd_valid;
		end
	end

	// Operands travel with their command
	always_ff @(posedge phi2) begin
		if (cmd_valid) begin
			ctrl  <= ctrl_d;
			bus_q <= bus;
		end
	end

	op_select_onehot: assert property (@(posedge phi2) disable iff (!rst_n)
		ctrl_valid |-> $onehot({ctrl.ands, ctrl.ors, ctrl.eors, ctrl.sums, ctrl.srs}))
		else $error("op selects not one-hot");

	daa_dsa_exclusive: assert property (@(posedge phi2) disable iff (!rst_n)
		cmd_valid |=> !(ctrl.daa && ctrl.dsa))
		else $error("daa and dsa both set");

endmodule

/* hdl/alu_execute.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_execute
	import alu_ctrl_pkg::*, alu_data_pkg::*;
(
	input  logic              phi2,
	input  logic              rst_n,
	input  logic              ctrl_valid,
	input  alu_ctrl_t         ctrl,
	input  alu_bus_t          bus_q,
	input  logic [`ALU_W-1:0] acc,
	output logic              hold_valid,
	output alu_hold_t         hold
);

	logic [`ALU_W-1:0] ai;
	logic [`ALU_W-1:0] bi;
	logic [`ALU_W-1:0] nands;
	logic [`ALU_W-1:0] nors;
	logic [`ALU_W-1:0] ands;
	logic [`ALU_W-1:0] ors;
	logic [`ALU_W-1:0] eors;
	logic [`ALU_W-1:0] sums;
	logic [`ALU_W:0]   carry;
	logic [`ALU_NIB:0] hi_dec;
	logic              dc;
	logic              dc7;
	logic [`ALU_W-1:0] sum_byte;
	logic [`ALU_W-1:0] res_d;
	alu_hold_t         hold_d;
	alu_hold_t         pay_q;
	alu_flags_t        flags_q;

	// AI/BI latches, transparent into the hold register
	always_comb begin
		if (ctrl.z_add)
			ai = '0;
		else if (ctrl.sb_add)
			ai = bus_q.sb;
		else if (ctrl.ac_add)
			ai = acc;
		else
			ai = '0;
	end

	always_comb begin
		if (ctrl.adl_add)
			bi = bus_q.adl;
		else if (ctrl.db_add)
			bi = bus_q.db;
		else if (ctrl.ndb_add)
			bi = ~bus_q.db;
		else
			bi = '0;
	end

	assign nands = ~(ai & bi);
	assign nors  = ~(ai | bi);
	assign ands  = ~nands;
	assign ors   = ~nors;
	assign eors  = ors & nands;

	// Ripple carry, generate from AND, propagate from OR
	always_comb begin
		carry[0] = ctrl.acin;
		for (int i = 0; i < `ALU_W; i++) begin
			carry[i+1] = ands[i] | (ors[i] & carry[i]);
		end
	end

	assign sums = eors ^ carry[`ALU_W-1:0];

	// Decimal half carry forces the carry into the high nibble
	assign dc = ctrl.daa & (carry[`ALU_NIB] | (sums[`ALU_NIB-1:0] > 4'd9));

	assign hi_dec = {1'b0, ai[`ALU_W-1:`ALU_NIB]} + {1'b0, bi[`ALU_W-1:`ALU_NIB]}
		+ {{`ALU_NIB{1'b0}}, dc};
	assign dc7 = hi_dec[`ALU_NIB] | (hi_dec[`ALU_NIB-1:0] > 4'd9);

	assign sum_byte = ctrl.daa ? {hi_dec[`ALU_NIB-1:0], sums[`ALU_NIB-1:0]} : sums;

	always_comb begin
		if (ctrl.srs)
			res_d = {1'b0, ands[`ALU_W-1:1]};
		else if (ctrl.ands)
			res_d = ands;
		else if (ctrl.ors)
			res_d = ors;
		else if (ctrl.eors)
			res_d = eors;
		else if (ctrl.sums)
			res_d = sum_byte;
		else
			res_d = '0;
	end

	always_comb begin
		hold_d = '0;
		hold_d.add = res_d;

		// Logic ops leave the carry alone
		if (ctrl.sums) begin
			hold_d.flags.acr = ctrl.daa ? dc7 : carry[`ALU_W];
			hold_d.flags.avr = carry[`ALU_W-1] ^ carry[`ALU_W];
		end else if (ctrl.srs) begin
			hold_d.flags.acr = ands[0]; // Bit shifted out
			hold_d.flags.avr = 1'b0;
		end else begin
			hold_d.flags.acr = flags_q.acr;
			hold_d.flags.avr = 1'b0;
		end

		hold_d.dc      = dc;
		hold_d.nib_c   = {carry[`ALU_W], carry[`ALU_NIB]};
		hold_d.daa     = ctrl.daa;
		hold_d.dsa     = ctrl.dsa;
		hold_d.sb_ac   = ctrl.sb_ac;
		hold_d.add_sb  = ctrl.add_sb;
		hold_d.add_adl = ctrl.add_adl;
	end

	always_ff @(posedge phi2) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
			flags_q    <= '0;
		end else begin
			hold_valid <= ctrl_valid;
			if (ctrl_valid)
				flags_q <= hold_d.flags;
		end
	end

	always_ff @(posedge phi2) begin
		if (ctrl_valid)
			pay_q <= hold_d;
	end

	always_comb begin
		hold       = pay_q;
		hold.flags = flags_q;
	end

	avr_sum_only: assert property (@(posedge phi2) disable iff (!rst_n)
		ctrl_valid && !ctrl.sums |=> hold_valid && !hold.flags.avr)
		else $error("avr set by a non-sum operation");

endmodule

/* hdl/alu_result.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_result
	import alu_data_pkg::*;
(
	input  logic              phi2,
	input  logic              rst_n,
	input  logic              hold_valid,
	input  alu_hold_t         hold,
	output logic [`ALU_W-1:0] acc,
	output logic [`ALU_W-1:0] sb_out,
	output logic [`ALU_W-1:0] adl_out,
	output logic              sb_drive,
	output logic              adl_drive,
	output alu_flags_t        flags
);

	localparam logic [`ALU_NIB-1:0] bcd_adj = `ALU_BCD_ADJ;

	logic [`ALU_NIB-1:0] lo;
	logic [`ALU_NIB-1:0] hi;
	logic [`ALU_W-1:0]   res;

	// BCD correction, nibble by nibble
	always_comb begin
		lo = hold.add[`ALU_NIB-1:0];
		hi = hold.add[`ALU_W-1:`ALU_NIB];
		if (hold.daa) begin
			if (hold.dc)
				lo = lo + bcd_adj;
			if (hold.flags.acr) // Decimal carry out
				hi = hi + bcd_adj;
		end else if (hold.dsa) begin
			// No carry out of a nibble means it borrowed
			if (!hold.nib_c[0])
				lo = lo - bcd_adj;
			if (!hold.nib_c[1])
				hi = hi - bcd_adj;
		end
		res = {hi, lo};
	end

	always_ff @(posedge phi2) begin
		if (!rst_n) begin
			acc       <= '0;
			flags     <= '0;
			sb_drive  <= 1'b0;
			adl_drive <= 1'b0;
		end else begin
			sb_drive  <= hold_valid & hold.add_sb;
			adl_drive <= hold_valid & hold.add_adl;
			if (hold_valid) begin
				flags <= hold.flags;
				if (hold.sb_ac)
					acc <= res;
			end
		end
	end

	always_ff @(posedge phi2) begin
		if (hold_valid && hold.add_sb)
			sb_out <= res;
		if (hold_valid && hold.add_adl)
			adl_out <= res;
	end

	// Holds only for BCD operands
	bcd_digits_valid: assert property (@(posedge phi2) disable iff (!rst_n)
		hold_valid && (hold.daa || hold.dsa) && hold.sb_ac
		|=> (acc[`ALU_NIB-1:0] <= 4'd9) && (acc[`ALU_W-1:`ALU_NIB] <= 4'd9))
		else $error("decimal result digit above 9");

endmodule

/* hdl/alu_top.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_top
	import alu_ctrl_pkg::*, alu_data_pkg::*;
(
	input  logic              phi2,
	input  logic              rst_n,
	input  logic              cmd_valid,
	input  alu_cmd_t          cmd,
	input  alu_bus_t          bus,
	output logic [`ALU_W-1:0] sb_out,
	output logic [`ALU_W-1:0] adl_out,
	output logic              sb_drive,
	output logic              adl_drive,
	output logic [`ALU_W-1:0] acc,
	output alu_flags_t        flags
);

	logic      ctrl_valid;
	alu_ctrl_t ctrl;
	alu_bus_t  bus_q;
	logic      hold_valid;
	alu_hold_t hold;

	alu_decode i_decode (
		.phi2       (phi2),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.bus        (bus),
		.ctrl_valid (ctrl_valid),
		.ctrl       (ctrl),
		.bus_q      (bus_q)
	);

	alu_execute i_execute (
		.phi2       (phi2),
		.rst_n      (rst_n),
		.ctrl_valid (ctrl_valid),
		.ctrl       (ctrl),
		.bus_q      (bus_q),
		.acc        (acc),       // Fed back for the AC source
		.hold_valid (hold_valid),
		.hold       (hold)
	);

	alu_result i_result (
		.phi2       (phi2),
		.rst_n      (rst_n),
		.hold_valid (hold_valid),
		.hold       (hold),
		.acc        (acc),
		.sb_out     (sb_out),
		.adl_out    (adl_out),
		.sb_drive   (sb_drive),
		.adl_drive  (adl_drive),
		.flags      (flags)
	);

endmodule

/* tb/alu_tb.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_tb
	import alu_ctrl_pkg::*, alu_data_pkg::*;
();

	localparam int max_cycles = 600; // About 280 commands and 80 idle cycles

	typedef struct packed {
		logic [`ALU_W-1:0] res;
		logic [`ALU_W-1:0] acc;    // Accumulator once this command retires
		alu_flags_t        flags;
		logic              to_adl;
		int                due;    // Cycle count when the strobe is seen
	} expect_t;

	logic              phi2;
	logic              rst_n;
	logic              cmd_valid;
	alu_cmd_t          cmd;
	alu_bus_t          bus;
	logic [`ALU_W-1:0] sb_out;
	logic [`ALU_W-1:0] adl_out;
	logic              sb_drive;
	logic              adl_drive;
	logic [`ALU_W-1:0] acc;
	alu_flags_t        flags;
	int                seed;
	int                cyc = 0;
	expect_t           pending[$];
	expect_t           head;
	logic [`ALU_W-1:0] model_acc;
	logic              model_acr;

	alu_top i_dut (
		.phi2      (phi2),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.bus       (bus),
		.sb_out    (sb_out),
		.adl_out   (adl_out),
		.sb_drive  (sb_drive),
		.adl_drive (adl_drive),
		.acc       (acc),
		.flags     (flags)
	);

	always #50 phi2 = ~phi2;

	always @(posedge phi2) begin
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("Timeout after %0d cycles, %0d results outstanding", cyc, pending.size());
			$display("CHECKS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic value_fail(input string name, input int expected, input int actual);
		$display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic plain_fail(input string what);
		$display("%0t %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "check failed");
	endtask

	function automatic logic [`ALU_W-1:0] rand_byte();
		int r;
		r = $random(seed);
		return r[`ALU_W-1:0];
	endfunction

	function automatic logic [`ALU_W-1:0] to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic logic [`ALU_W-1:0] rand_bcd();
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return to_bcd(r % 100);
	endfunction

	function automatic int bcd_value(input logic [`ALU_W-1:0] v);
		return int'(v[7:4]) * 10 + int'(v[3:0]);
	endfunction

	function automatic alu_cmd_t make_cmd(input alu_op_e op, input a_src_e a_src,
		input b_src_e b_src, input logic cin, input logic dec, input logic to_ac,
		input logic to_adl);
		alu_cmd_t c;
		c.op = op;
		c.a_src = a_src;
		c.b_src = b_src;
		c.carry_in = cin;
		c.decimal = dec;
		c.to_ac = to_ac;
		c.to_sb = !to_adl; // Exactly one output bus per command
		c.to_adl = to_adl;
		return c;
	endfunction

	function automatic expect_t predict(input alu_cmd_t c, input alu_bus_t b);
		logic [`ALU_W-1:0] ai;
		logic [`ALU_W-1:0] bi;
		logic [`ALU_W:0]   bin;
		int                dv;
		expect_t           e;
		ai = (c.a_src == a_sb) ? b.sb : (c.a_src == a_ac) ? model_acc : '0;
		bi = (c.b_src == b_db) ? b.db : (c.b_src == b_ndb) ? ~b.db : b.adl;
		bin = {1'b0, ai} + {1'b0, bi} + {{`ALU_W{1'b0}}, c.carry_in};
		e = '0;
		e.flags.acr = model_acr; // Logic ops keep the carry
		case (c.op)
			op_and: e.res = ai & bi;
			op_or:  e.res = ai | bi;
			op_eor: e.res = ai ^ bi;
			op_sr: begin
				e.res = (ai & bi) >> 1;
				e.flags.acr = ai[0] & bi[0];
			end
			default: begin
				e.res = bin[`ALU_W-1:0];
				e.flags.acr = bin[`ALU_W];
				e.flags.avr = (ai[7] == bi[7]) && (bin[7] != ai[7]);
				if (c.decimal && c.b_src == b_db) begin
					dv = bcd_value(ai) + bcd_value(b.db) + int'(c.carry_in);
					e.res = to_bcd(dv % 100);
					e.flags.acr = dv >= 100;
				end else if (c.decimal && c.b_src == b_ndb) begin
					// Carry set means no borrow
					dv = bcd_value(ai) - bcd_value(b.db) - 1 + int'(c.carry_in);
					e.res = to_bcd((dv + 100) % 100);
					e.flags.acr = dv >= 0;
				end
			end
		endcase
		e.acc = c.to_ac ? e.res : model_acc;
		e.to_adl = c.to_adl;
		return e;
	endfunction

	task automatic issue(input alu_cmd_t c, input logic [`ALU_W-1:0] sb,
		input logic [`ALU_W-1:0] db, input logic [`ALU_W-1:0] adl);
		alu_bus_t b;
		expect_t  e;
		b.sb = sb;
		b.db = db;
		b.adl = adl;
		e = predict(c, b);
		e.due = cyc + `ALU_LATENCY + 1; // cyc has not yet counted this edge
		model_acc = e.acc;
		model_acr = e.flags.acr;
		pending.push_back(e);
		cmd_valid <= 1'b1;
		cmd <= c;
		bus <= b;
		@(posedge phi2);
	endtask

	task automatic idle(input int n);
		cmd_valid <= 1'b0;
		repeat (n) @(posedge phi2);
	endtask

	// Outputs are settled by the falling edge
	always @(negedge phi2) begin
		if (rst_n) begin
			if (pending.size() != 0 && pending[0].due < cyc)
				plain_fail("No output strobe for a command that should have completed");
			if (sb_drive || adl_drive) begin
				if (pending.size() == 0) begin
					plain_fail("Output strobe seen with no command in flight");
				end else begin
					head = pending.pop_front();
					assert (cyc == head.due) else value_fail("latency", head.due, cyc);
					assert (sb_drive == !head.to_adl)
						else value_fail("sb_drive", int'(!head.to_adl), int'(sb_drive));
					assert (adl_drive == head.to_adl)
						else value_fail("adl_drive", int'(head.to_adl), int'(adl_drive));
					if (head.to_adl) begin
						assert (adl_out == head.res)
							else value_fail("adl_out", int'(head.res), int'(adl_out));
					end else begin
						assert (sb_out == head.res)
							else value_fail("sb_out", int'(head.res), int'(sb_out));
					end
					assert (acc == head.acc) else value_fail("acc", int'(head.acc), int'(acc));
					assert (flags == head.flags)
						else value_fail("flags", int'(head.flags), int'(flags));
				end
			end
		end
	end

	initial begin
		int               i;
		logic [`ALU_W-1:0] rb;
		seed = 32'h578c_52f7;
		phi2 = 1'b0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		bus = '0;
		model_acc = '0;
		model_acr = 1'b0;
		repeat (3) @(posedge phi2);
		rst_n <= 1'b1;
		@(negedge phi2);
		assert (!sb_drive && !adl_drive) else plain_fail("Output strobe high after reset");
		assert (acc == '0) else value_fail("acc", 0, int'(acc));
		assert (flags == '0) else value_fail("flags", 0, int'(flags));
		@(posedge phi2);

		// Binary add and subtract
		for (i = 0; i < 60; i++) begin
			rb = rand_byte();
			issue(make_cmd(op_sum, a_sb, rb[0] ? b_ndb : b_db, rb[1], 1'b0, 1'b0, 1'b0),
				rand_byte(), rand_byte(), rand_byte());
		end

		// Logic ops with a sum now and then so the carry moves
		for (i = 0; i < 60; i++) begin
			rb = rand_byte();
			issue(make_cmd((i % 4 == 0) ? op_and : (i % 4 == 1) ? op_or :
				(i % 4 == 2) ? op_eor : op_sum, a_sb, b_db, rb[0], 1'b0, 1'b0, 1'b0),
				rand_byte(), rand_byte(), rand_byte());
		end

		for (i = 0; i < 40; i++) begin
			rb = rand_byte();
			issue(make_cmd(op_sr, (rb[3:2] == 2'b00) ? a_zero : a_sb, rb[0] ? b_adl : b_db,
				rb[4], 1'b0, 1'b0, rb[1]), rand_byte(), rand_byte(), rand_byte());
		end

		// Decimal add and subtract into the accumulator
		for (i = 0; i < 60; i++) begin
			rb = rand_byte();
			issue(make_cmd(op_sum, a_sb, rb[0] ? b_ndb : b_db, rb[1], 1'b1, 1'b1, 1'b0),
				rand_bcd(), rand_bcd(), rand_byte());
		end

		// Accumulator reads three cycles after each write
		for (i = 0; i < 20; i++) begin
			issue(make_cmd(op_or, a_zero, b_db, 1'b0, 1'b0, 1'b1, 1'b0),
				rand_byte(), rand_byte(), rand_byte());
			idle(2);
			rb = rand_byte();
			issue(make_cmd(op_sum, a_ac, b_db, rb[0], 1'b0, 1'b1, 1'b0),
				rand_byte(), rand_byte(), rand_byte());
			idle(2);
			issue(make_cmd(op_eor, a_ac, b_adl, 1'b0, 1'b0, 1'b0, rb[1]),
				rand_byte(), rand_byte(), rand_byte());
		end

		idle(1);
		while (pending.size() != 0)
			@(posedge phi2);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/alu_ctrl_pkg.sv
hdl/alu_data_pkg.sv
hdl/alu_decode.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/alu_top.sv
tb/alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ALU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module alu_tb \
	--Mdir obj_dir -o alu_sim > build.log 2>&1 \
	&& ./obj_dir/alu_sim > sim.log 2>&1 \
	|| { cat build.log; echo "Build or simulation exited with an error" >> sim.log; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
